/* src/fb_pkg.sv */
package fb_pkg;

    // field widths shared by the ports and the entry type.
    localparam int INSN_W = 32;
    localparam int PRE_W  = 64;
    localparam int EXCP_W = 16;
    localparam int PLV_W  = 2;

    // one buffered instruction, 179 bits.
    typedef struct packed {
        logic [INSN_W-1:0] ir;
        logic [INSN_W-1:0] pc;
        logic [INSN_W-1:0] npc;       // predicted next pc of the packet.
        logic [PRE_W-1:0]  pre;       // branch prediction word.
        logic [EXCP_W-1:0] excp_arg;
        logic [PLV_W-1:0]  plv;
        logic              pair_head; // first of a two instruction packet.
    } fb_entry_t;

endpackage

/* src/fb_wr_if.sv */
`timescale 1ns/100ps

interface fb_wr_if #(
    parameter int DEPTH = 16
);

    localparam int PTR_W = $clog2(DEPTH);

    fb_pkg::fb_entry_t entry0;   // written at wr_ptr.
    fb_pkg::fb_entry_t entry1;   // written at wr_ptr + 1.
    logic              we0;
    logic              we1;
    logic [PTR_W-1:0]  wr_ptr;

    // packet splitter side.
    modport split (
        output entry0,
        output entry1
    );

    modport ctrl (
        output we0,
        output we1,
        output wr_ptr
    );

    // storage sees the whole write side.
    modport ram (
        input entry0,
        input entry1,
        input we0,
        input we1,
        input wr_ptr
    );

endinterface

/* src/fb_packet_split.sv */
`timescale 1ns/100ps

module fb_packet_split (
    input  logic [fb_pkg::INSN_W-1:0]   pc,
    input  logic [fb_pkg::INSN_W-1:0]   npc,
    input  logic [2*fb_pkg::INSN_W-1:0] irin,
    input  logic [fb_pkg::PRE_W-1:0]    pre,
    input  logic [fb_pkg::PLV_W-1:0]    plv,
    input  logic [fb_pkg::EXCP_W-1:0]   excp_arg,
    input  logic                        flag,
    fb_wr_if.split                      wr
);

    localparam int INSN_W = fb_pkg::INSN_W;

    fb_pkg::fb_entry_t first;
    fb_pkg::fb_entry_t second;

    always_comb begin
        first.ir        = irin[INSN_W-1:0]; // low word is the older one.
        first.pc        = pc;
        first.npc       = npc;
        first.pre       = pre;
        first.excp_arg  = excp_arg;
        first.plv       = plv;
        first.pair_head = flag;
    end

    // second of a pair shares the prediction but not the exception.
    always_comb begin
        second.ir        = irin[2*INSN_W-1:INSN_W];
        second.pc        = pc + INSN_W'(4);
        second.npc       = npc;
        second.pre       = pre;
        second.excp_arg  = '0;
        second.plv       = plv;
        second.pair_head = 1'b0;
    end

    assign wr.entry0 = first;
    assign wr.entry1 = second; // only written when paired.

endmodule

/* src/fb_ctrl.sv */
`timescale 1ns/100ps

module fb_ctrl #(
    parameter int DEPTH = 16
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       flush,
    input  logic                       stall,
    input  logic                       icache_valid,
    input  logic                       flag,
    input  logic                       take0,
    input  logic                       take1,
    output logic                       stall_fetch_buffer,
    output logic [$clog2(DEPTH)-1:0]   rd_ptr,
    output logic [$clog2(DEPTH):0]     count,
    fb_wr_if.ctrl                      wr
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] cnt;
    logic             accept;
    logic [1:0]       n_wr;
    logic [1:0]       n_req;
    logic [1:0]       n_rd;

    // full once fewer than two slots are free.
    assign stall_fetch_buffer = cnt > CNT_W'(DEPTH - 2);

    assign accept = icache_valid && !stall_fetch_buffer && !stall && !flush;

    always_comb begin
        if (!accept)
            n_wr = 2'd0;
        else if (flag)
            n_wr = 2'd2;
        else
            n_wr = 2'd1;
    end

    // take1 alone does nothing.
    always_comb begin
        if (!take0)
            n_req = 2'd0;
        else if (take1)
            n_req = 2'd2;
        else
            n_req = 2'd1;
    end

    // never retire more than is held.
    always_comb begin
        if (CNT_W'(n_req) > cnt)
            n_rd = cnt[1:0];
        else
            n_rd = n_req;
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            head <= '0;
            tail <= '0;
            cnt  <= '0;
        end else if (!stall) begin
            head <= head + PTR_W'(n_rd);
            tail <= tail + PTR_W'(n_wr); // wraps, DEPTH is a power of two.
            cnt  <= cnt + CNT_W'(n_wr) - CNT_W'(n_rd);
        end
    end

    assign wr.we0    = accept;
    assign wr.we1    = accept && flag;
    assign wr.wr_ptr = tail;

    assign rd_ptr = head;
    assign count  = cnt;

endmodule

/* src/fb_entry_ram.sv */
`timescale 1ns/100ps

module fb_entry_ram #(
    parameter int DEPTH = 16
) (
    input  logic                      clk,
    input  logic [$clog2(DEPTH)-1:0]  rd_ptr,
    output fb_pkg::fb_entry_t         rd_entry0,
    output fb_pkg::fb_entry_t         rd_entry1,
    fb_wr_if.ram                      wr
);

    localparam int PTR_W = $clog2(DEPTH);

    fb_pkg::fb_entry_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr1;
    logic [PTR_W-1:0] rd_ptr1;

    // second ports sit one slot further round the ring.
    assign wr_ptr1 = wr.wr_ptr + PTR_W'(1);
    assign rd_ptr1 = rd_ptr + PTR_W'(1);

    always_ff @(posedge clk) begin
        if (wr.we0) begin
            mem[wr.wr_ptr] <= wr.entry0;
        end
        if (wr.we1) begin
            mem[wr_ptr1] <= wr.entry1;
        end
    end

    // read is combinational, slot validity is decided downstream.
    assign rd_entry0 = mem[rd_ptr];
    assign rd_entry1 = mem[rd_ptr1];

endmodule

/* src/fb_issue_select.sv */
`timescale 1ns/100ps

module fb_issue_select #(
    parameter int DEPTH = 16
) (
    input  fb_pkg::fb_entry_t         rd_entry0,
    input  fb_pkg::fb_entry_t         rd_entry1,
    input  logic [$clog2(DEPTH):0]    count,
    output fb_pkg::fb_entry_t         slot0,
    output fb_pkg::fb_entry_t         slot1,
    output logic                      valid0,
    output logic                      valid1
);

    localparam int CNT_W = $clog2(DEPTH) + 1;

    assign valid0 = count >= CNT_W'(1);
    assign valid1 = count >= CNT_W'(2);

    // stale storage is never shown to decode.
    assign slot0 = valid0 ? rd_entry0 : '0;
    assign slot1 = valid1 ? rd_entry1 : '0;

endmodule

/* src/fetch_buffer_top.sv */
`timescale 1ns/100ps

module fetch_buffer_top #(
    parameter int DEPTH = 16
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          flush,
    input  logic                          stall,
    input  logic                          icache_valid,
    input  logic                          flag,        // packet holds two instructions.
    input  logic                          take0,
    input  logic                          take1,
    input  logic [fb_pkg::INSN_W-1:0]     pc,
    input  logic [fb_pkg::INSN_W-1:0]     npc,
    input  logic [2*fb_pkg::INSN_W-1:0]   irin,
    input  logic [fb_pkg::PRE_W-1:0]      pre,
    input  logic [fb_pkg::PLV_W-1:0]      plv,
    input  logic [fb_pkg::EXCP_W-1:0]     excp_arg,
    output logic [fb_pkg::INSN_W-1:0]     ir0,
    output logic [fb_pkg::INSN_W-1:0]     pc0,
    output logic [fb_pkg::INSN_W-1:0]     npc0,
    output logic [fb_pkg::PRE_W-1:0]      pre0,
    output logic [fb_pkg::PLV_W-1:0]      plv0,
    output logic [fb_pkg::EXCP_W-1:0]     excp_arg0,
    output logic                          pair_head0,
    output logic                          valid0,
    output logic [fb_pkg::INSN_W-1:0]     ir1,
    output logic [fb_pkg::INSN_W-1:0]     pc1,
    output logic [fb_pkg::INSN_W-1:0]     npc1,
    output logic [fb_pkg::PRE_W-1:0]      pre1,
    output logic [fb_pkg::PLV_W-1:0]      plv1,
    output logic [fb_pkg::EXCP_W-1:0]     excp_arg1,
    output logic                          pair_head1,
    output logic                          valid1,
    output logic                          stall_fetch_buffer
);

    localparam int PTR_W = $clog2(DEPTH);

    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W:0]    count;
    fb_pkg::fb_entry_t rd_entry0;
    fb_pkg::fb_entry_t rd_entry1;
    fb_pkg::fb_entry_t slot0;
    fb_pkg::fb_entry_t slot1;

    fb_wr_if #(.DEPTH(DEPTH)) wr_bus ();

    fb_packet_split u_split (
        .pc       (pc),
        .npc      (npc),
        .irin     (irin),
        .pre      (pre),
        .plv      (plv),
        .excp_arg (excp_arg),
        .flag     (flag),
        .wr       (wr_bus.split)
    );

    fb_ctrl #(.DEPTH(DEPTH)) u_ctrl (
        .clk                (clk),
        .rst_n              (rst_n),
        .flush              (flush),
        .stall              (stall),
        .icache_valid       (icache_valid),
        .flag               (flag),
        .take0              (take0),
        .take1              (take1),
        .stall_fetch_buffer (stall_fetch_buffer),
        .rd_ptr             (rd_ptr),
        .count              (count),
        .wr                 (wr_bus.ctrl)
    );

    fb_entry_ram #(.DEPTH(DEPTH)) u_ram (
        .clk       (clk),
        .rd_ptr    (rd_ptr),
        .rd_entry0 (rd_entry0),
        .rd_entry1 (rd_entry1),
        .wr        (wr_bus.ram)
    );

    fb_issue_select #(.DEPTH(DEPTH)) u_select (
        .rd_entry0 (rd_entry0),
        .rd_entry1 (rd_entry1),
        .count     (count),
        .slot0     (slot0),
        .slot1     (slot1),
        .valid0    (valid0),
        .valid1    (valid1)
    );

    // slot 0 is the older instruction.
    assign ir0        = slot0.ir;
    assign pc0        = slot0.pc;
    assign npc0       = slot0.npc;
    assign pre0       = slot0.pre;
    assign plv0       = slot0.plv;
    assign excp_arg0  = slot0.excp_arg;
    assign pair_head0 = slot0.pair_head;

    assign ir1        = slot1.ir;
    assign pc1        = slot1.pc;
    assign npc1       = slot1.npc;
    assign pre1       = slot1.pre;
    assign plv1       = slot1.plv;
    assign excp_arg1  = slot1.excp_arg;
    assign pair_head1 = slot1.pair_head;

endmodule

/* test/tb_fetch_buffer.sv */
`timescale 1ns/100ps

module tb_fetch_buffer;

    localparam int DEPTH   = 16;
    localparam int FIELDS  = 10;   // words per stimulus record.
    localparam int MAX_REC = 64;
    localparam STIM_FILE   = "test/fb_stim.txt";

    logic                          clk;
    logic                          rst_n;
    logic                          flush;
    logic                          stall;
    logic                          icache_valid;
    logic                          flag;
    logic                          take0;
    logic                          take1;
    logic [fb_pkg::INSN_W-1:0]     pc;
    logic [fb_pkg::INSN_W-1:0]     npc;
    logic [2*fb_pkg::INSN_W-1:0]   irin;
    logic [fb_pkg::PRE_W-1:0]      pre;
    logic [fb_pkg::PLV_W-1:0]      plv;
    logic [fb_pkg::EXCP_W-1:0]     excp_arg;
    logic [fb_pkg::INSN_W-1:0]     ir0, pc0, npc0, ir1, pc1, npc1;
    logic [fb_pkg::PRE_W-1:0]      pre0, pre1;
    logic [fb_pkg::PLV_W-1:0]      plv0, plv1;
    logic [fb_pkg::EXCP_W-1:0]     excp_arg0, excp_arg1;
    logic                          pair_head0, pair_head1;
    logic                          valid0, valid1;
    logic                          stall_fetch_buffer;

    logic [31:0]       stim_mem [0:FIELDS*MAX_REC-1];
    int                n_rec;
    bit                loaded;
    int                slot_errors;
    int                flag_errors;
    int                other_errors;
    fb_pkg::fb_entry_t model_q [$];   // oldest entry at the front.
    fb_pkg::fb_entry_t got0;
    fb_pkg::fb_entry_t got1;

    fetch_buffer_top #(.DEPTH(DEPTH)) dut_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .flush              (flush),
        .stall              (stall),
        .icache_valid       (icache_valid),
        .flag               (flag),
        .take0              (take0),
        .take1              (take1),
        .pc                 (pc),
        .npc                (npc),
        .irin               (irin),
        .pre                (pre),
        .plv                (plv),
        .excp_arg           (excp_arg),
        .ir0                (ir0),
        .pc0                (pc0),
        .npc0               (npc0),
        .pre0               (pre0),
        .plv0               (plv0),
        .excp_arg0          (excp_arg0),
        .pair_head0         (pair_head0),
        .valid0             (valid0),
        .ir1                (ir1),
        .pc1                (pc1),
        .npc1               (npc1),
        .pre1               (pre1),
        .plv1               (plv1),
        .excp_arg1          (excp_arg1),
        .pair_head1         (pair_head1),
        .valid1             (valid1),
        .stall_fetch_buffer (stall_fetch_buffer)
    );

    // field order follows the entry struct.
    assign got0 = {ir0, pc0, npc0, pre0, excp_arg0, plv0, pair_head0};
    assign got1 = {ir1, pc1, npc1, pre1, excp_arg1, plv1, pair_head1};

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_slot(input string name, input fb_pkg::fb_entry_t got,
                              input fb_pkg::fb_entry_t exp);
        if (got !== exp) begin
            slot_errors++;
            $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            flag_errors++;
            $display("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_outputs();
        fb_pkg::fb_entry_t exp0;
        fb_pkg::fb_entry_t exp1;
        exp0 = '0;   // empty slots read as zero.
        exp1 = '0;
        if (model_q.size() >= 1)
            exp0 = model_q[0];
        if (model_q.size() >= 2)
            exp1 = model_q[1];
        check_slot("slot0", got0, exp0);
        check_slot("slot1", got1, exp1);
        check_bit("valid0", valid0, model_q.size() >= 1);
        check_bit("valid1", valid1, model_q.size() >= 2);
        check_bit("stall_fetch_buffer", stall_fetch_buffer, model_q.size() > DEPTH - 2);
    endtask

    task automatic load_stim();
        int fd;
        n_rec = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            other_errors++;
            $display("stimulus file %s could not be opened", STIM_FILE);
        end else begin
            $fclose(fd);
            $readmemh(STIM_FILE, stim_mem);
            while (n_rec < MAX_REC && !$isunknown(stim_mem[n_rec*FIELDS]))
                n_rec++;
            if (n_rec == 0) begin
                other_errors++;
                $display("stimulus file %s holds no records", STIM_FILE);
            end
        end
    endtask

    task automatic drive_record(input int r);
        int b;
        b            = r * FIELDS;
        icache_valid = stim_mem[b][0];
        flag         = stim_mem[b+1][0];
        take0        = stim_mem[b+2][0];
        take1        = stim_mem[b+3][0];
        stall        = stim_mem[b+4][0];
        flush        = stim_mem[b+5][0];
        pc           = stim_mem[b+6];
        npc          = stim_mem[b+7];
        plv          = stim_mem[b+8][fb_pkg::PLV_W-1:0];
        excp_arg     = stim_mem[b+9][fb_pkg::EXCP_W-1:0];
        irin         = {$urandom, $urandom};
        pre          = {$urandom, $urandom};
    endtask

    // applies what the next rising edge does with the inputs just driven.
    task automatic update_model();
        fb_pkg::fb_entry_t e0;
        fb_pkg::fb_entry_t e1;
        int                n_rd;
        bit                full;
        if (flush) begin
            model_q.delete();
        end else if (!stall) begin
            full = model_q.size() > DEPTH - 2;
            n_rd = take0 ? (take1 ? 2 : 1) : 0;
            if (n_rd > model_q.size())
                n_rd = model_q.size();
            repeat (n_rd)
                model_q.delete(0);
            if (icache_valid && !full) begin
                e0.ir        = irin[fb_pkg::INSN_W-1:0];
                e0.pc        = pc;
                e0.npc       = npc;
                e0.pre       = pre;
                e0.excp_arg  = excp_arg;
                e0.plv       = plv;
                e0.pair_head = flag;
                model_q.push_back(e0);
                if (flag) begin
                    e1           = e0;
                    e1.ir        = irin[2*fb_pkg::INSN_W-1:fb_pkg::INSN_W];
                    e1.pc        = pc + 32'd4;
                    e1.excp_arg  = '0;
                    e1.pair_head = 1'b0;
                    model_q.push_back(e1);
                end
            end
        end
    endtask

    initial begin
        wait (loaded);
        #((n_rec + 16 + 20) * 100);
        $display("timeout, the run did not finish within %0d clock cycles", n_rec + 36);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        int seed;
        seed         = 32'hb2cc;
        void'($urandom(seed));
        slot_errors  = 0;
        flag_errors  = 0;
        other_errors = 0;
        rst_n        = 1'b0;
        flush        = 1'b0;
        stall        = 1'b0;
        icache_valid = 1'b0;
        flag         = 1'b0;
        take0        = 1'b0;
        take1        = 1'b0;
        pc           = '0;
        npc          = '0;
        irin         = '0;
        pre          = '0;
        plv          = '0;
        excp_arg     = '0;
        load_stim();
        loaded = 1'b1;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        for (int r = 0; r < n_rec; r++) begin
            @(negedge clk);
            check_outputs();
            drive_record(r);
            update_model();
        end
        @(negedge clk);
        check_outputs();
        $display("errors: slot %0d, flag %0d, other %0d",
                 slot_errors, flag_errors, other_errors);
        if (slot_errors + flag_errors + other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* compile.f */
src/fb_pkg.sv
src/fb_wr_if.sv
src/fb_packet_split.sv
src/fb_ctrl.sv
src/fb_entry_ram.sv
src/fb_issue_select.sv
src/fetch_buffer_top.sv
test/tb_fetch_buffer.sv

/* test/fb_stim.txt */
// icache_valid flag take0 take1 stall flush pc npc plv excp_arg, all hex.
// one record per clock cycle, instruction and prediction words are random.
// test 1, single packets
1 0 0 0 0 0 00001000 00001004 0 0011
1 0 0 0 0 0 00001004 00001008 1 0022
1 0 1 0 0 0 00001008 0000100c 3 0033
0 0 1 0 0 0 00000000 00000000 0 0000
0 0 1 0 0 0 00000000 00000000 0 0000
// test 2, paired packets
1 1 0 0 0 0 00002000 00002040 2 00a1
1 1 1 0 0 0 00002008 00002040 2 00a2
0 0 1 1 0 0 00000000 00000000 0 0000
1 1 1 1 0 0 00002010 00002040 1 00a3
0 0 1 1 0 0 00000000 00000000 0 0000
// test 3, retire counts
1 0 0 1 0 0 00003000 00003004 0 0b01
1 1 0 1 0 0 00003004 0000300c 0 0b02
0 0 0 1 0 0 00000000 00000000 0 0000
0 0 1 1 0 0 00000000 00000000 0 0000
0 0 1 1 0 0 00000000 00000000 0 0000
0 0 1 1 0 0 00000000 00000000 0 0000
0 0 1 0 0 0 00000000 00000000 0 0000
// test 4, filling up and pointer wrap
1 1 0 0 0 0 00004000 00004100 1 0c00
1 1 0 0 0 0 00004008 00004100 1 0c01
1 1 0 0 0 0 00004010 00004100 1 0c02
1 1 0 0 0 0 00004018 00004100 1 0c03
1 1 0 0 0 0 00004020 00004100 1 0c04
1 1 0 0 0 0 00004028 00004100 1 0c05
1 1 0 0 0 0 00004030 00004100 1 0c06
1 1 0 0 0 0 00004038 00004100 1 0c07
1 1 0 0 0 0 00004040 00004100 1 0c08
1 0 0 0 0 0 00004090 00004100 2 0c09
1 1 1 1 0 0 000040a0 00004100 2 0c0a
1 1 1 1 0 0 000040b0 00004100 3 0c0b
1 0 1 0 0 0 000040c0 00004100 3 0c0c
0 0 1 1 0 0 00000000 00000000 0 0000
0 0 1 1 0 0 00000000 00000000 0 0000
0 0 1 1 0 0 00000000 00000000 0 0000
// test 5, stall freezes the buffer
1 1 0 0 0 0 00005000 00005040 1 0d01
1 0 0 0 0 0 00005008 00005040 1 0d02
1 1 1 1 1 0 00005010 00005040 1 0d03
1 0 1 0 1 0 00005018 00005040 1 0d04
0 0 1 1 1 0 00000000 00000000 0 0000
0 0 1 1 0 0 00000000 00000000 0 0000
// test 6, flush in a stream
1 1 0 0 0 0 00006000 00006100 2 0e01
1 1 1 0 0 0 00006008 00006100 2 0e02
1 1 1 1 0 1 00006010 00006100 2 0e03
1 0 0 0 0 1 00006018 00006100 2 0e04
1 0 0 0 0 0 00006020 00006024 3 0e05
0 0 1 0 0 0 00000000 00000000 0 0000
1 1 1 1 1 1 00006030 00006100 1 0e06
0 0 0 0 0 0 00000000 00000000 0 0000
